// ==== src.f ====
src/cpu_pin_pkg.sv
src/cpu_core.sv
src/pin_bus_bridge.sv
src/cpu_pin_top.sv
test/pin_mem_model.sv
test/tb_cpu_pin_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module tb_cpu_pin_top -o tb_sim
	./obj_dir/tb_sim | awk '{print} /^all tests passed$$/{ok=1} END{exit !ok}'

clean:
	rm -rf obj_dir

// ==== test/tb_cpu_pin_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu pin tile testbench
// directed programs run through the pin frame memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_cpu_pin_top;

  import cpu_pin_pkg::*;

  localparam int addr_a = 16;
  localparam int addr_b = 17;
  localparam int addr_c = 18;
  // frames: 7 + 7 + 4 + 7 + 8 * 7, each run adds reset and idle time
  localparam int total_frames = 81;
  localparam int total_runs   = 12;
  localparam int budget_clks  = total_frames * 12 + total_runs * 60;

  logic       clk;
  logic       arst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uo_out;
  logic [7:0] uio_in;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;
  int         errors;
  logic [31:0] rng;

  cpu_pin_top i_cpu_pin_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .ena     (ena),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  pin_mem_model i_pin_mem_model (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (i_cpu_pin_top.req.valid),
    .done      (i_cpu_pin_top.done),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .uio_in    (uio_in)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] encode(input logic [7:0] op, input int a);
    return {op, a[23:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic hold_reset();
    @(posedge clk);
    #1 arst_n = 1'b0;
    i_pin_mem_model.clear_log();
    repeat (4) @(posedge clk);
  endtask

  task automatic wait_halt();
    int idle;
    int last;
    idle = 0;
    last = i_pin_mem_model.log_addr.size();
    while (idle < 40) begin
      @(posedge clk);
      if (i_pin_mem_model.log_addr.size() != last) begin
        last = i_pin_mem_model.log_addr.size();
        idle = 0;
      end else begin
        idle++;
      end
    end
  endtask

  task automatic run_program();
    hold_reset();
    #1 arst_n = 1'b1;
    wait_halt();
  endtask

  // load A, add B, store C, halt
  task automatic load_sum_program(input logic [31:0] a, input logic [31:0] b);
    i_pin_mem_model.clear_mem();
    i_pin_mem_model.write_word(0, encode(op_load, addr_a));
    i_pin_mem_model.write_word(1, encode(op_add, addr_b));
    i_pin_mem_model.write_word(2, encode(op_store, addr_c));
    i_pin_mem_model.write_word(3, encode(op_halt, 0));
    i_pin_mem_model.write_word(addr_a, a);
    i_pin_mem_model.write_word(addr_b, b);
  endtask

  task automatic check_sum_run(input string name, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] sum;
    sum = a + b;
    check_value({name, " mem c"}, sum, i_pin_mem_model.mem[addr_c]);
    check_value({name, " frames"}, 7, i_pin_mem_model.log_addr.size());
    if (i_pin_mem_model.log_addr.size() == 7) begin
      // frame 5 is the store
      check_value({name, " wr flag"}, 1, i_pin_mem_model.log_write[5]);
      check_value({name, " wr addr"}, addr_c, i_pin_mem_model.log_addr[5]);
      check_value({name, " wr data"}, sum, i_pin_mem_model.log_wdata[5]);
      check_value({name, " wr oe"}, 32'hffff_ffff, i_pin_mem_model.log_oe[5]);
      check_value({name, " wr flag byte"}, 8'h01, i_pin_mem_model.log_flag[5]);
      check_value({name, " rd oe"}, 0, i_pin_mem_model.log_oe[3]);
    end
  endtask

  task automatic test_reset();
    i_pin_mem_model.clear_mem();
    hold_reset();
    check_value("reset uo_out", 0, uo_out);
    check_value("reset uio_out", 0, uio_out);
    check_value("reset uio_oe", 0, uio_oe);
    #1 arst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value("release uo_out", 0, uo_out);
    check_value("release uio_out", 0, uio_out);
    check_value("release uio_oe", 0, uio_oe);
  endtask

  task automatic test_frame_format();
    load_sum_program(32'h1111_2222, 32'h0000_0003);
    run_program();
    if (i_pin_mem_model.log_addr.size() < 2) begin
      $display("frame format: fewer than two frames were seen");
      errors++;
    end else begin
      check_value("format addr", 0, i_pin_mem_model.log_addr[0]);
      check_value("format oe", 0, i_pin_mem_model.log_oe[0]);
      check_value("format flag", 0, i_pin_mem_model.log_flag[0]);
      check_value("format length", 10, i_pin_mem_model.log_len[0]);
      if (i_pin_mem_model.log_start[1] - i_pin_mem_model.log_done[0] > 1) begin
        $display("frame format: next frame started late after done");
        errors++;
      end
    end
  endtask

  task automatic test_jump();
    i_pin_mem_model.clear_mem();
    i_pin_mem_model.write_word(0, encode(op_load, addr_a));
    i_pin_mem_model.write_word(1, encode(op_jump, 3));
    i_pin_mem_model.write_word(2, encode(op_store, addr_c));
    i_pin_mem_model.write_word(3, encode(op_halt, 0));
    i_pin_mem_model.write_word(addr_a, 32'hdead_0001);
    i_pin_mem_model.write_word(addr_c, 32'h0c0c_0c0c);
    run_program();
    check_value("jump mem c", 32'h0c0c_0c0c, i_pin_mem_model.mem[addr_c]);
    check_value("jump frames", 4, i_pin_mem_model.log_addr.size());
    if (i_pin_mem_model.log_addr.size() == 4) begin
      check_value("jump fetch 0", 0, i_pin_mem_model.log_addr[0]);
      check_value("jump data", addr_a, i_pin_mem_model.log_addr[1]);
      check_value("jump fetch 1", 1, i_pin_mem_model.log_addr[2]);
      check_value("jump target", 3, i_pin_mem_model.log_addr[3]);
    end
  endtask

  task automatic test_halt();
    int count;
    load_sum_program(32'h0000_0010, 32'h0000_0020);
    run_program();
    count = i_pin_mem_model.log_addr.size();
    check_value("halt frames", 7, count);
    if (count == 7) begin
      check_value("halt fetch addr", 3, i_pin_mem_model.log_addr[6]);
    end
    repeat (40) @(posedge clk);
    if (i_pin_mem_model.log_addr.size() != count) begin
      $display("halt: a frame started after the halt");
      errors++;
    end
  endtask

  task automatic test_random_sums();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      a   = rng;
      rng = xorshift(rng);
      b   = rng;
      load_sum_program(a, b);
      run_program();
      check_sum_run($sformatf("random %0d", i), a, b);
    end
  endtask

  initial begin
    #(budget_clks * 4);
    $display("watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    ena    = 1'b1;
    ui_in  = 8'h00;
    errors = 0;
    rng    = 32'd9;
    test_reset();
    test_frame_format();
    load_sum_program(32'hffff_fff0, 32'h0000_0020); // wraps past 2^32
    run_program();
    check_sum_run("load add store", 32'hffff_fff0, 32'h0000_0020);
    test_jump();
    test_halt();
    test_random_sums();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== test/pin_mem_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pin memory model
// answers pin frames from a word array and logs every frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module pin_mem_model (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       req_valid,  // tapped from the core
  input  logic       done,       // tapped from the bridge
  input  logic [7:0] uo_out,
  input  logic [7:0] uio_out,
  input  logic [7:0] uio_oe,
  output logic [7:0] uio_in
);

  logic [31:0] mem [0:255];
  logic [3:0]  p;         // mirrors the bridge phase
  logic [23:0] addr;
  logic [31:0] wdata;
  logic [31:0] oe_word;
  logic [31:0] rword;
  logic        wflag;
  int          cyc;
  int          start_cyc;

  logic [23:0] log_addr [$];
  logic        log_write [$];
  logic [31:0] log_wdata [$];
  logic [31:0] log_oe [$];
  logic [7:0]  log_flag [$];
  int          log_start [$];
  int          log_len [$];   // clocks from leaving phase 0 to done
  int          log_done [$];

  initial uio_in <= 8'h00;

  // fill depends on the whole address
  task automatic clear_mem();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a00_0000 | i;
    end
  endtask

  task automatic write_word(input int a, input logic [31:0] w);
    mem[a] = w;
  endtask

  task automatic clear_log();
    log_addr.delete();
    log_write.delete();
    log_wdata.delete();
    log_oe.delete();
    log_flag.delete();
    log_start.delete();
    log_len.delete();
    log_done.delete();
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p   = 4'd0;
      cyc = 0;
    end else begin
      cyc++;
      // done pulse seen one edge after it rises
      if (done) begin
        log_len.push_back(cyc - start_cyc);
        log_done.push_back(cyc);
      end
      // pins show the byte of phase p-1
      case (p)
        4'd2: begin
          addr[7:0]    = uo_out;
          wdata[7:0]   = uio_out;
          oe_word[7:0] = uio_oe;
        end
        4'd3: begin
          addr[15:8]    = uo_out;
          wdata[15:8]   = uio_out;
          oe_word[15:8] = uio_oe;
        end
        4'd4: begin
          addr[23:16]    = uo_out;
          wdata[23:16]   = uio_out;
          oe_word[23:16] = uio_oe;
        end
        4'd5: begin
          wdata[31:24]   = uio_out;
          oe_word[31:24] = uio_oe;
        end
        4'd6: wflag = uo_out[0];
        default: ;
      endcase
      if (p == 4'd6) begin
        log_flag.push_back(uo_out);
      end
      // same rule as the bridge
      if (p == 4'd0) begin
        if (req_valid && !done) begin
          p         = 4'd1;
          start_cyc = cyc;
        end
      end else if (p == 4'd9) begin
        p = 4'd0;
        if (wflag) begin
          mem[addr[7:0]] = wdata;
        end
        log_addr.push_back(addr);
        log_write.push_back(wflag);
        log_wdata.push_back(wdata);
        log_oe.push_back(oe_word);
        log_start.push_back(start_cyc);
      end else begin
        p = p + 4'd1;
      end
      rword = (addr < 24'd256) ? mem[addr[7:0]] : {8'h00, addr};
      if (p >= 4'd6) begin
        uio_in <= #1 rword[(p-6)*8 +: 8];
      end
    end
  end

endmodule

// ==== src/cpu_pin_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu pin tile top
// joins the cpu core to the pin bus bridge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cpu_pin_top (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ena,     // tied high when powered
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,  // address bytes, then write flag
  input  logic [7:0] uio_in,  // read bytes
  output logic [7:0] uio_out, // write data bytes
  output logic [7:0] uio_oe
);

  import cpu_pin_pkg::*;

  bus_req_t  req;
  bus_word_u rdata;
  logic      done;

  cpu_core i_cpu_core (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .rdata  (rdata),
    .done   (done)
  );

  pin_bus_bridge i_pin_bus_bridge (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .rdata   (rdata),
    .done    (done),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

  // pins with no function in this tile
  logic unused_inputs;
  assign unused_inputs = &{ena, ui_in, 1'b0};

endmodule

// ==== src/pin_bus_bridge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pin bus bridge
// carries one bus access over the 8-bit pins in ten clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module pin_bus_bridge (
  input  logic                   clk,
  input  logic                   arst_n,
  input  cpu_pin_pkg::bus_req_t  req,
  output cpu_pin_pkg::bus_word_u rdata,
  output logic                   done,
  output logic [7:0]             uo_out,
  output logic [7:0]             uio_out,
  output logic [7:0]             uio_oe,
  input  logic [7:0]             uio_in
);

  import cpu_pin_pkg::*;

  logic [3:0]       phase;
  bus_req_t         req_q;     // request held for the frame
  logic [3:0][7:0]  cap_bytes; // read bytes, low byte first
  logic             start;
  logic [7:0]       oe_byte;

  // done blocks a restart of the request just served
  assign start   = (phase == 4'd0) && req.valid && !done;
  assign oe_byte = {8{req_q.write}};

  // phase counter and done strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= '0;
      done  <= 1'b0;
    end else begin
      done <= (phase == frame_last);
      if (phase == 4'd0) begin
        if (start) begin
          phase <= 4'd1;
        end
      end else if (phase == frame_last) begin
        phase <= 4'd0;
      end else begin
        phase <= phase + 4'd1;
      end
    end
  end

  // request copy, taken as the frame starts
  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= req;
    end
  end

  // registered pins, each phase shows up one clock later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
    end else begin
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
      case (phase)
        4'd1: begin
          uo_out  <= req_q.addr[7:0];
          uio_out <= req_q.wdata[7:0];
          uio_oe  <= oe_byte;
        end
        4'd2: begin
          uo_out  <= req_q.addr[15:8];
          uio_out <= req_q.wdata[15:8];
          uio_oe  <= oe_byte;
        end
        4'd3: begin
          uo_out  <= req_q.addr[23:16];
          uio_out <= req_q.wdata[23:16];
          uio_oe  <= oe_byte;
        end
        4'd4: begin
          uo_out  <= 8'h00;              // address is only 24 bits
          uio_out <= req_q.wdata[31:24];
          uio_oe  <= oe_byte;
        end
        phase_flag: uo_out <= {7'd0, req_q.write};
        default: ;
      endcase
    end
  end

  // read bytes shift in from the top, phases 6 to 9
  always_ff @(posedge clk) begin
    if (phase > phase_flag) begin
      cap_bytes <= {uio_in, cap_bytes[3:1]};
    end
  end

  assign rdata.data = cap_bytes;

endmodule

// ==== src/cpu_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// accumulator cpu core
// fetch and execute sequenced as single bus accesses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cpu_core (
  input  logic                   clk,
  input  logic                   arst_n,
  output cpu_pin_pkg::bus_req_t  req,
  input  cpu_pin_pkg::bus_word_u rdata,
  input  logic                   done
);

  import cpu_pin_pkg::*;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_halt
  } state_t;

  state_t      state;
  logic [23:0] pc;
  logic [31:0] acc;
  instr_t      ir;      // instruction in execute
  instr_t      fetched; // word arriving on a fetch
  logic        is_data_op;

  assign fetched = rdata.instr;

  // only these three need a second frame
  always_comb begin
    case (fetched.opcode)
      op_load, op_add, op_store: is_data_op = 1'b1;
      default:                   is_data_op = 1'b0;
    endcase
  end

  // control state and accumulator
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_fetch;
      pc    <= '0;
      acc   <= '0;
    end else if (done) begin
      case (state)
        st_fetch: begin
          if (fetched.opcode == op_halt) begin
            state <= st_halt;
          end else if (fetched.opcode == op_jump) begin
            pc <= fetched.operand; // stays in fetch
          end else begin
            pc <= pc + 24'd1;
            if (is_data_op) begin
              state <= st_exec;
            end
          end
        end
        st_exec: begin
          case (ir.opcode)
            op_load: acc <= rdata.data;
            op_add:  acc <= acc + rdata.data; // wraps at 32 bits
            default: acc <= acc;              // store leaves acc alone
          endcase
          state <= st_fetch;
        end
        default: state <= st_halt; // halted until reset
      endcase
    end
  end

  // instruction register, loaded at the end of each fetch
  always_ff @(posedge clk) begin
    if (state == st_fetch && done) begin
      ir <= fetched;
    end
  end

  // request follows the state directly
  always_comb begin
    req = '0;
    case (state)
      st_fetch: begin
        req.valid = 1'b1;
        req.addr  = pc;
      end
      st_exec: begin
        req.valid = 1'b1;
        req.write = (ir.opcode == op_store);
        req.addr  = ir.operand;
        req.wdata = acc;
      end
      default: req = '0;  // no more frames
    endcase
  end

endmodule

// ==== src/cpu_pin_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu pin package
// opcodes, pin frame phases and the shared bus types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_pin_pkg;

  // opcodes, any other value is a no-op
  localparam logic [7:0] op_load  = 8'd1;
  localparam logic [7:0] op_add   = 8'd2;
  localparam logic [7:0] op_store = 8'd3;
  localparam logic [7:0] op_jump  = 8'd4;
  localparam logic [7:0] op_halt  = 8'd5;

  // pin frame, phase 0 is idle
  localparam logic [3:0] frame_last = 4'd9;  // last read byte
  localparam logic [3:0] phase_flag = 4'd5;  // write flag on uo_out[0]

  // one bus access from the core
  typedef struct packed {
    logic        valid;  // level, held until done
    logic        write;
    logic [23:0] addr;   // word address
    logic [31:0] wdata;
  } bus_req_t;

  // instruction word layout
  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] operand;  // data address or jump target
  } instr_t;

  // read word, used as an instruction on fetch
  // and as a plain value on execute
  typedef union packed {
    logic [31:0] data;
    instr_t      instr;
  } bus_word_u;

endpackage
